//--- io_pkg.sv
// bus widths, i/o word map, error bit positions, timing constants
package io_pkg;

  // --------------------
  // bus
  // --------------------
  localparam int ADDR_W   = 22;  // word address, byte bits 23:2
  localparam int DATA_W   = 32;
  localparam int IO_OFS_W = 6;   // 64 words in the i/o page

  // upper address bits of the i/o page, all ones
  localparam logic [ADDR_W-IO_OFS_W-1:0] IO_PAGE = '1;

  // --------------------
  // i/o word offsets
  // --------------------
  localparam logic [IO_OFS_W-1:0] IO_TMR = 6'd48;  // ms timer, one word
  localparam logic [IO_OFS_W-1:0] IO_SCS = 6'd46;  // sys ctrl, words 46..47
  localparam logic [IO_OFS_W-1:0] IO_STM = 6'd40;  // stack monitor, words 40..43
  localparam logic [IO_OFS_W-1:0] IO_WD  = 6'd36;  // watchdog, one word

  // timing
  localparam int MS_TICK_DIV = 50_000;  // 50 MHz system clock
  localparam int RST_PULSE   = 4;       // cycles of sys reset after an error

  // --------------------
  // errors
  // --------------------
  // lowest bit wins when several come at once
  localparam int ERR_W      = 4;
  localparam int ERR_CODE_W = $clog2(ERR_W);
  localparam int ERR_EXT    = 0;  // abort button or similar
  localparam int ERR_WD     = 1;  // watchdog expired
  localparam int ERR_LIM    = 2;  // stack below limit
  localparam int ERR_HOT    = 3;  // stack in hot zone

  // device widths
  localparam int SP_W = 24;  // stack pointer and pc
  localparam int WD_W = 16;  // watchdog timeout and elapsed count

endpackage

//--- ms_timer.sv
// millisecond prescaler and running millisecond counter
`timescale 1ns/1ns

module ms_timer #(
  parameter int tick_div = io_pkg::MS_TICK_DIV  // clock cycles per ms
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      stb,
  output logic [io_pkg::DATA_W-1:0] data_out,  // ms since reset
  output logic                      ms_tick
);
  import io_pkg::*;

  localparam int DIV_W = (tick_div > 1) ? $clog2(tick_div) : 1;

  logic [DIV_W-1:0]  div_cnt;  // prescaler
  logic [DATA_W-1:0] ms_cnt;

  // prescaler, tick on wrap
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      div_cnt <= '0;
      ms_tick <= 1'b0;
    end else if (div_cnt == DIV_W'(tick_div - 1)) begin
      div_cnt <= '0;
      ms_tick <= 1'b1;  // high for one cycle
    end else begin
      div_cnt <= div_cnt + 1'b1;
      ms_tick <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) ms_cnt <= '0;
    else if (ms_tick) ms_cnt <= ms_cnt + 1'b1;  // one cycle after the tick
  end

  assign data_out = stb ? ms_cnt : '0;  // read only, writes dropped

  a_tick_single: assert property (@(posedge clk) disable iff (!rst_n) ms_tick |=> !ms_tick);

endmodule

//--- watchdog.sv
// reloadable millisecond watchdog with sticky trigger
`timescale 1ns/1ns

module watchdog (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      stb,
  input  logic                      we,
  input  logic [io_pkg::WD_W-1:0]   data_in,   // new timeout in ms
  input  logic                      tick,      // ms tick
  output logic [io_pkg::DATA_W-1:0] data_out,  // elapsed, timeout
  output logic                      trig
);
  import io_pkg::*;

  logic [WD_W-1:0] timeout;   // 0 = disabled
  logic [WD_W-1:0] elapsed;   // ms since last kick
  logic [WD_W-1:0] elapsed_nxt;
  logic            wr;

  assign wr          = stb & we;
  assign elapsed_nxt = elapsed + 1'b1;

  // --------------------
  // kick and count
  // --------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      timeout <= '0;
      elapsed <= '0;
      trig    <= 1'b0;
    end else if (wr) begin
      // kick: reload and restart
      timeout <= data_in;
      elapsed <= '0;
      trig    <= 1'b0;
    end else if (tick && !trig) begin
      elapsed <= elapsed_nxt;  // holds once expired
      if (timeout != '0 && elapsed_nxt == timeout) begin
        trig <= 1'b1;  // stays until next kick
      end
    end
  end

  // elapsed in the upper half, timeout in the lower
  assign data_out = DATA_W'({elapsed, timeout});

endmodule

//--- stack_mon.sv
// stack limit and hot-zone comparators, lowest stack pointer watermark
`timescale 1ns/1ns

module stack_mon (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      stb,
  input  logic                      we,
  input  logic [1:0]                addr,     // word 0..3
  input  logic [io_pkg::SP_W-1:0]   data_in,
  input  logic [io_pkg::SP_W-1:0]   sp_in,    // sampled cpu sp
  output logic [io_pkg::DATA_W-1:0] data_out,
  output logic                      trig_lim,
  output logic                      trig_hot
);
  import io_pkg::*;

  logic [SP_W-1:0] lim;    // word 0, 0 = off
  logic [SP_W-1:0] hot;    // word 1, 0 = off
  logic [SP_W-1:0] wmark;  // word 2, lowest sp seen
  logic            wr;

  assign wr = stb & we;

  // bound registers
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lim <= '0;
      hot <= '0;
    end else if (wr) begin
      case (addr)
        2'd0:    lim <= data_in;
        2'd1:    hot <= data_in;
        default: ;  // words 2, 3 handled elsewhere or read only
      endcase
    end
  end

  // --------------------
  // comparators, one cycle behind sp
  // --------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      trig_lim <= 1'b0;
      trig_hot <= 1'b0;
    end else begin
      trig_lim <= (lim != '0) && (sp_in < lim);
      trig_hot <= (hot != '0) && (sp_in < hot);
    end
  end

  // watermark, any write to word 2 restarts it
  always_ff @(posedge clk) begin
    if (!rst_n) wmark <= '1;
    else if (wr && addr == 2'd2) wmark <= '1;
    else if (sp_in < wmark) wmark <= sp_in;  // only ever moves down
  end

  always_comb begin
    case (addr)
      2'd0:    data_out = DATA_W'(lim);
      2'd1:    data_out = DATA_W'(hot);
      2'd2:    data_out = DATA_W'(wmark);
      default: data_out = DATA_W'({trig_hot, trig_lim});  // status bits
    endcase
  end

  a_wmark_down: assert property (@(posedge clk) disable iff (!rst_n)
    !(wr && addr == 2'd2) |=> wmark <= $past(wmark));

endmodule

//--- sys_ctrl.sv
// system control: first-error latch, error pc capture, reset pulse
`timescale 1ns/1ns

module sys_ctrl (
  input  logic                      clk,
  input  logic                      rst_n,     // board reset only
  input  logic                      stb,
  input  logic                      we,
  input  logic                      addr,      // 0 ctrl/status, 1 error pc
  input  logic [io_pkg::DATA_W-1:0] data_in,
  input  logic [io_pkg::ERR_W-1:0]  err_sig,   // bit 0 highest priority
  input  logic [io_pkg::SP_W-1:0]   err_addr,  // cpu pc
  output logic [io_pkg::DATA_W-1:0] data_out,
  output logic                      sys_rst_n
);
  import io_pkg::*;

  localparam int PULSE_W = $clog2(RST_PULSE + 1);

  logic                  rst_en;     // reset on error
  logic                  err_valid;
  logic [ERR_CODE_W-1:0] err_code;
  logic [SP_W-1:0]       err_pc;
  logic [PULSE_W-1:0]    pulse_cnt;  // remaining reset cycles
  logic                  wr_ctrl;
  logic                  err_new;    // first error, latch now

  // index of the lowest set error bit
  function automatic logic [ERR_CODE_W-1:0] first_err(input logic [ERR_W-1:0] sig);
    logic [ERR_CODE_W-1:0] code;
    code = '0;
    for (int i = ERR_W - 1; i >= 0; i--) begin
      if (sig[i]) code = ERR_CODE_W'(i);  // lower bits overwrite
    end
    return code;
  endfunction

  assign wr_ctrl = stb & we & ~addr;
  assign err_new = ~err_valid & (|err_sig);

  // --------------------
  // control and error latch
  // --------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rst_en    <= 1'b0;
      err_valid <= 1'b0;
      err_code  <= '0;
    end else begin
      if (wr_ctrl) rst_en <= data_in[0];
      if (err_new) begin
        err_valid <= 1'b1;
        err_code  <= first_err(err_sig);
      end else if (wr_ctrl && data_in[1]) begin
        err_valid <= 1'b0;  // clear, next error latches fresh
      end
    end
  end

  always_ff @(posedge clk) begin
    if (err_new) err_pc <= err_addr;  // pc at the moment of latching
  end

  // reset pulse starts on the latching edge
  always_ff @(posedge clk) begin
    if (!rst_n) pulse_cnt <= '0;
    else if (err_new && rst_en) pulse_cnt <= PULSE_W'(RST_PULSE);
    else if (pulse_cnt != '0) pulse_cnt <= pulse_cnt - 1'b1;
  end

  assign sys_rst_n = (pulse_cnt == '0);

  // word 0: code in 5:4, valid bit 1, enable bit 0
  always_comb begin
    if (addr) data_out = DATA_W'(err_pc);
    else      data_out = DATA_W'({err_code, 2'b00, err_valid, rst_en});
  end

  a_pulse_len: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(sys_rst_n) |-> ##[1:RST_PULSE] sys_rst_n);

endmodule

//--- io_sys.sv
// i/o page top: address decode, read data and ack mux, error vector, devices
`timescale 1ns/1ns

module io_sys #(
  parameter int tick_div = io_pkg::MS_TICK_DIV  // clock cycles per ms
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      bus_stb,
  input  logic                      bus_we,
  input  logic [io_pkg::ADDR_W-1:0] bus_addr,   // word address
  input  logic [io_pkg::DATA_W-1:0] bus_dout,   // write data from master
  output logic [io_pkg::DATA_W-1:0] bus_din,    // read data to master
  output logic                      bus_ack,
  input  logic [io_pkg::SP_W-1:0]   cpu_sp,
  input  logic [io_pkg::SP_W-1:0]   cpu_pc,
  input  logic                      err_ext,
  output logic                      sys_rst_n,
  output logic                      wd_trig
);
  import io_pkg::*;

  logic [IO_OFS_W-1:0] io_ofs;     // word inside the page
  logic                io_stb;
  logic                tmr_stb;
  logic                scs_stb;
  logic                stm_stb;
  logic                wd_stb;
  logic                dev_rst_n;  // board reset or error reset
  logic [DATA_W-1:0]   tmr_dout;
  logic [DATA_W-1:0]   scs_dout;
  logic [DATA_W-1:0]   stm_dout;
  logic [DATA_W-1:0]   wd_dout;
  logic                ms_tick;
  logic                stm_trig_lim;
  logic                stm_trig_hot;
  logic [ERR_W-1:0]    err_vec;

  assign dev_rst_n = rst_n & sys_rst_n;  // sys_ctrl itself stays on rst_n

  // --------------------
  // address decode
  // --------------------
  assign io_ofs  = bus_addr[IO_OFS_W-1:0];
  assign io_stb  = bus_stb && (bus_addr[ADDR_W-1:IO_OFS_W] == IO_PAGE);
  assign tmr_stb = io_stb && (io_ofs == IO_TMR);
  assign scs_stb = io_stb && (io_ofs[IO_OFS_W-1:1] == IO_SCS[IO_OFS_W-1:1]);  // 2 words
  assign stm_stb = io_stb && (io_ofs[IO_OFS_W-1:2] == IO_STM[IO_OFS_W-1:2]);  // 4 words
  assign wd_stb  = io_stb && (io_ofs == IO_WD);

  // read data mux, unmapped page words read zero
  always_comb begin
    if (tmr_stb)      bus_din = tmr_dout;
    else if (scs_stb) bus_din = scs_dout;
    else if (stm_stb) bus_din = stm_dout;
    else if (wd_stb)  bus_din = wd_dout;
    else              bus_din = '0;
  end

  // every device acks in the strobe cycle, so any page hit acks
  // outside the page nothing answers
  assign bus_ack = io_stb;

  // error vector in priority order
  always_comb begin
    err_vec          = '0;
    err_vec[ERR_EXT] = err_ext;
    err_vec[ERR_WD]  = wd_trig;
    err_vec[ERR_LIM] = stm_trig_lim;
    err_vec[ERR_HOT] = stm_trig_hot;
  end

  // --------------------
  // devices
  // --------------------
  ms_timer #(.tick_div(tick_div)) tmr_0 (
    .clk(clk), .rst_n(dev_rst_n), .stb(tmr_stb),
    .data_out(tmr_dout), .ms_tick(ms_tick)
  );

  watchdog wd_0 (
    .clk(clk), .rst_n(dev_rst_n), .stb(wd_stb), .we(bus_we),
    .data_in(bus_dout[WD_W-1:0]), .tick(ms_tick),
    .data_out(wd_dout), .trig(wd_trig)
  );

  stack_mon stm_0 (
    .clk(clk), .rst_n(dev_rst_n), .stb(stm_stb), .we(bus_we),
    .addr(bus_addr[1:0]), .data_in(bus_dout[SP_W-1:0]), .sp_in(cpu_sp),
    .data_out(stm_dout), .trig_lim(stm_trig_lim), .trig_hot(stm_trig_hot)
  );

  sys_ctrl scs_0 (
    .clk(clk), .rst_n(rst_n), .stb(scs_stb), .we(bus_we),
    .addr(bus_addr[0]), .data_in(bus_dout), .err_sig(err_vec), .err_addr(cpu_pc),
    .data_out(scs_dout), .sys_rst_n(sys_rst_n)
  );

endmodule

//--- tb_clk.sv
// testbench clock and power-on reset generator
`timescale 1ns/1ns

module tb_clk #(
  parameter int period     = 8,  // ns
  parameter int rst_cycles = 3   // rising edges with rst_n low
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // release on a falling edge, clear of the sampling edge
  initial begin
    rst_n = 1'b0;
    repeat (rst_cycles) @(posedge clk);
    @(negedge clk);
    rst_n <= 1'b1;
  end

endmodule

//--- tb_io_sys.sv
// io_sys testbench with bus master tasks, reference functions, compare process and test sequence
`timescale 1ns/1ns

module tb_io_sys;
  import io_pkg::*;

  localparam int TICK_DIV    = 20;  // short ms for simulation
  localparam int ACK_TIMEOUT = 16;  // cycles a transfer may wait for ack

  logic              clk;
  logic              rst_n;
  logic              bus_stb;
  logic              bus_we;
  logic [ADDR_W-1:0] bus_addr;
  logic [DATA_W-1:0] bus_dout;
  logic [DATA_W-1:0] bus_din;
  logic              bus_ack;
  logic [SP_W-1:0]   cpu_sp;
  logic [SP_W-1:0]   cpu_pc;
  logic              err_ext;
  logic              sys_rst_n;
  logic              wd_trig;
  int unsigned       cyc;      // cycles since the timer left reset
  int unsigned       rd_cyc;   // cyc when the last read was sampled
  int                kind_q[$];  // 0 word, 1 error code, 2 address
  logic [DATA_W-1:0] got_q[$];
  logic [DATA_W-1:0] exp_q[$];
  string             what_q[$];

  tb_clk #(.period(8), .rst_cycles(3)) clk_gen (.clk(clk), .rst_n(rst_n));

  io_sys #(.tick_div(TICK_DIV)) uut (
    .clk(clk), .rst_n(rst_n), .bus_stb(bus_stb), .bus_we(bus_we),
    .bus_addr(bus_addr), .bus_dout(bus_dout), .bus_din(bus_din), .bus_ack(bus_ack),
    .cpu_sp(cpu_sp), .cpu_pc(cpu_pc), .err_ext(err_ext),
    .sys_rst_n(sys_rst_n), .wd_trig(wd_trig)
  );

  // timer runs on board reset and error reset alike
  always @(posedge clk) begin
    if (!(rst_n && sys_rst_n)) cyc <= 0;
    else cyc <= cyc + 1;
  end

  // --------------------
  // reference model
  // --------------------
  // first tick after TICK_DIV cycles and the count moves one cycle later
  function automatic logic [DATA_W-1:0] ref_ms(input int unsigned cycles);
    if (cycles == 0) return '0;
    return DATA_W'((cycles - 1) / TICK_DIV);
  endfunction

  function automatic logic [ERR_CODE_W-1:0] ref_code(input logic [ERR_W-1:0] errs);
    int pos;
    pos = 0;
    while (pos < ERR_W - 1 && !errs[pos]) pos++;  // lowest bit wins
    return ERR_CODE_W'(pos);
  endfunction

  function automatic logic [DATA_W-1:0] ref_status(input logic en, input logic valid,
                                                   input logic [ERR_CODE_W-1:0] code);
    return (DATA_W'(code) << 4) | (DATA_W'(valid) << 1) | DATA_W'(en);
  endfunction

  function automatic logic [ADDR_W-1:0] io_addr(input logic [IO_OFS_W-1:0] ofs);
    return {IO_PAGE, ofs};
  endfunction

  // --------------------
  // checks
  // --------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string what, input logic [DATA_W-1:0] got,
                                 input logic [DATA_W-1:0] exp);
    abort_run($sformatf("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_word(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                            input string what);
    if (got !== exp) report_mismatch(what, got, exp);
  endtask

  task automatic check_code(input logic [ERR_CODE_W-1:0] got,
                            input logic [ERR_CODE_W-1:0] exp, input string what);
    if (got !== exp) report_mismatch(what, DATA_W'(got), DATA_W'(exp));
  endtask

  task automatic check_addr(input logic [SP_W-1:0] got, input logic [SP_W-1:0] exp,
                            input string what);
    if (got !== exp) report_mismatch(what, DATA_W'(got), DATA_W'(exp));
  endtask

  task automatic queue_check(input int kind, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp, input string what);
    kind_q.push_back(kind);
    got_q.push_back(got);
    exp_q.push_back(exp);
    what_q.push_back(what);
  endtask

  // drains pending reads once per cycle
  always @(posedge clk) begin : compare
    int                kind;
    logic [DATA_W-1:0] got;
    logic [DATA_W-1:0] exp;
    string             what;
    while (kind_q.size() != 0) begin
      kind = kind_q.pop_front();
      got  = got_q.pop_front();
      exp  = exp_q.pop_front();
      what = what_q.pop_front();
      case (kind)
        0:       check_word(got, exp, what);
        1:       check_code(got[ERR_CODE_W-1:0], exp[ERR_CODE_W-1:0], what);
        default: check_addr(got[SP_W-1:0], exp[SP_W-1:0], what);
      endcase
    end
  end

  // --------------------
  // bus master
  // --------------------
  // called on a falling edge with the request already driven
  task automatic wait_ack(input logic [ADDR_W-1:0] addr);
    int waited;
    waited = 0;
    #1;  // decode settles
    while (!bus_ack) begin
      if (waited == ACK_TIMEOUT) abort_run($sformatf("no bus ack from address %h", addr));
      @(negedge clk);
      #1;
      waited++;
    end
  endtask

  task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    bus_stb  = 1'b1;
    bus_we   = 1'b1;
    bus_addr = addr;
    bus_dout = data;
    wait_ack(addr);
    @(negedge clk);  // write lands on the rising edge in between
    bus_stb = 1'b0;
    bus_we  = 1'b0;
  endtask

  task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
    bus_stb  = 1'b1;
    bus_we   = 1'b0;
    bus_addr = addr;
    wait_ack(addr);
    data   = bus_din;
    rd_cyc = cyc;
    @(negedge clk);
    bus_stb = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge clk);
  endtask

  // --------------------
  // test sequence
  // --------------------
  initial begin : main
    logic [DATA_W-1:0]     rd;
    logic [SP_W-1:0]       pc;
    logic [SP_W-1:0]       lim;
    logic [SP_W-1:0]       hot;
    logic [SP_W-1:0]       sp;
    logic [SP_W-1:0]       sp_min;
    logic [ERR_CODE_W-1:0] code;
    int                    waited;
    void'($urandom(96102));
    bus_stb  = 1'b0;
    bus_we   = 1'b0;
    bus_addr = '0;
    bus_dout = '0;
    cpu_sp   = '1;
    cpu_pc   = '0;
    err_ext  = 1'b0;
    waited   = 0;
    while (rst_n !== 1'b1) begin
      if (waited == 10) abort_run("reset was never released");
      @(negedge clk);
      waited++;
    end

    // timer at random points
    repeat (6) begin
      idle($urandom_range(0, 2 * TICK_DIV));
      bus_read(io_addr(IO_TMR), rd);
      queue_check(0, rd, ref_ms(rd_cyc), "timer count");
    end

    // watchdog expiry latches its code and the pc
    pc     = SP_W'($urandom());
    cpu_pc = pc;
    bus_write(io_addr(IO_WD), 32'd3);
    waited = 0;
    while (!wd_trig) begin
      if (waited > 4 * TICK_DIV) abort_run("watchdog did not fire within 4 ticks");
      @(negedge clk);
      waited++;
    end
    idle(1);  // latch follows the trigger by a cycle
    code = ref_code(ERR_W'(1) << ERR_WD);
    bus_read(io_addr(IO_SCS), rd);
    queue_check(0, rd, ref_status(1'b0, 1'b1, code), "status after watchdog");
    queue_check(1, rd >> 4, DATA_W'(code), "watchdog error code");
    bus_read(io_addr(IO_SCS | 6'd1), rd);
    queue_check(2, rd, DATA_W'(pc), "pc at watchdog error");
    bus_read(io_addr(IO_WD), rd);
    queue_check(0, rd & 32'hffff, 32'd3, "watchdog timeout");
    bus_write(io_addr(IO_WD), 32'd0);   // timeout 0 turns the trigger off
    bus_write(io_addr(IO_SCS), 32'h2);  // clear error

    // stack monitor with random bounds and sp
    repeat (3) begin
      lim = SP_W'($urandom());
      hot = SP_W'($urandom());
      bus_write(io_addr(IO_STM), DATA_W'(lim));
      bus_write(io_addr(IO_STM | 6'd1), DATA_W'(hot));
      bus_write(io_addr(IO_STM | 6'd2), 32'd0);  // watermark restart
      sp_min = '1;
      repeat (12) begin
        sp     = SP_W'($urandom());
        cpu_sp = sp;
        if (sp < sp_min) sp_min = sp;
        @(negedge clk);
      end
      bus_read(io_addr(IO_STM | 6'd3), rd);
      queue_check(0, rd, {30'd0, hot != 0 && sp < hot, lim != 0 && sp < lim}, "stack triggers");
      bus_read(io_addr(IO_STM | 6'd2), rd);
      queue_check(0, rd, DATA_W'(sp_min), "stack watermark");
      bus_read(io_addr(IO_STM), rd);
      queue_check(0, rd, DATA_W'(lim), "stack limit");
    end

    // --------------------
    // error priority and clear
    // --------------------
    bus_write(io_addr(IO_STM), 32'd0);
    bus_write(io_addr(IO_STM | 6'd1), 32'd0);
    idle(2);  // triggers drop
    bus_write(io_addr(IO_SCS), 32'h2);
    bus_read(io_addr(IO_SCS), rd);
    queue_check(0, rd & 32'h3, 32'd0, "status after clear");
    pc     = SP_W'($urandom());
    cpu_pc = pc;
    cpu_sp = 24'h000100;
    bus_write(io_addr(IO_STM | 6'd1), 32'h800000);  // hot zone covers sp
    @(negedge clk);  // hot trigger rises on the next edge
    err_ext = 1'b1;
    @(negedge clk);
    err_ext = 1'b0;
    code = ref_code(ERR_W'((1 << ERR_EXT) | (1 << ERR_HOT)));
    bus_read(io_addr(IO_SCS), rd);
    queue_check(0, rd, ref_status(1'b0, 1'b1, code), "status, ext and hot together");
    queue_check(1, rd >> 4, DATA_W'(code), "priority error code");
    bus_read(io_addr(IO_SCS | 6'd1), rd);
    queue_check(2, rd, DATA_W'(pc), "pc at ext error");
    bus_write(io_addr(IO_STM | 6'd1), 32'd0);
    idle(2);
    bus_write(io_addr(IO_SCS), 32'h2);
    pc     = SP_W'($urandom());
    cpu_pc = pc;
    bus_write(io_addr(IO_STM), 32'h800000);  // limit above sp
    idle(2);  // trigger then latch
    code = ref_code(ERR_W'(1) << ERR_LIM);
    bus_read(io_addr(IO_SCS), rd);
    queue_check(0, rd, ref_status(1'b0, 1'b1, code), "status, fresh limit error");
    queue_check(1, rd >> 4, DATA_W'(code), "fresh error code");
    bus_read(io_addr(IO_SCS | 6'd1), rd);
    queue_check(2, rd, DATA_W'(pc), "pc at limit error");

    // --------------------
    // reset on error and decode
    // --------------------
    bus_write(io_addr(IO_STM), 32'd0);
    idle(2);
    bus_write(io_addr(IO_SCS), 32'h3);  // enable reset and clear
    err_ext = 1'b1;
    @(negedge clk);
    err_ext = 1'b0;
    waited  = 0;
    while (!sys_rst_n) begin
      if (waited > 4 * RST_PULSE) abort_run("system reset stuck low");
      @(negedge clk);
      waited++;
    end
    check_word(DATA_W'(waited), DATA_W'(RST_PULSE), "system reset length");
    idle($urandom_range(0, TICK_DIV));
    bus_read(io_addr(IO_TMR), rd);
    queue_check(0, rd, ref_ms(rd_cyc), "timer after error reset");
    code = ref_code(ERR_W'(1) << ERR_EXT);
    bus_read(io_addr(IO_SCS), rd);
    queue_check(0, rd, ref_status(1'b1, 1'b1, code), "status kept over reset");
    queue_check(1, rd >> 4, DATA_W'(code), "error code kept over reset");
    for (int i = 0; i < 4; i++) begin
      bus_read(io_addr(IO_OFS_W'(5 + i * 15)), rd);  // 5, 20, 35, 50 have no device
      queue_check(0, rd, 32'd0, "unmapped word");
    end

    waited = 0;
    while (kind_q.size() != 0) begin
      if (waited == 4) abort_run("compare queue did not drain");
      @(negedge clk);
      waited++;
    end
    $display("Test OK");
    $finish;
  end

endmodule

//--- flist.f
io_pkg.sv
ms_timer.sv
watchdog.sv
stack_mon.sv
sys_ctrl.sv
io_sys.sv
tb_clk.sv
tb_io_sys.sv

//--- Bender.yml
package:
  name: io_sys

sources:
  - io_pkg.sv
  - ms_timer.sv
  - watchdog.sv
  - stack_mon.sv
  - sys_ctrl.sv
  - io_sys.sv
  - target: test
    files:
      - tb_clk.sv
      - tb_io_sys.sv
